// File: rtl/farm_macros.svh
/*
 * Multiplier farm configuration
 * Lane count, operand width and the number of shift-add steps per product
 */

`ifndef FARM_MACROS_SVH
`define FARM_MACROS_SVH

// The farm needs at least two multiplier lanes
`define FARM_NUM_LANES 4

// Width of one unsigned operand; the product is twice as wide
`define FARM_OPND_W 8

// One shift-add iteration per multiplier bit
`define FARM_MUL_STEPS `FARM_OPND_W

`endif

// File: rtl/farm_pkg.sv
/*
 * Multiplier farm types
 * Operand, product and lane index types shared by the farm blocks
 */

`default_nettype none

`include "farm_macros.svh"

package farm_pkg;

    // One unsigned operand
    typedef logic [`FARM_OPND_W-1:0] operand_t;

    // Full-width unsigned product of two operands
    typedef logic [2*`FARM_OPND_W-1:0] product_t;

    // Lane pointer used by both round-robin ends of the farm
    typedef logic [$clog2(`FARM_NUM_LANES)-1:0] lane_idx_t;

endpackage : farm_pkg

`default_nettype wire

// File: rtl/rr_distributor.sv
/*
 * Strict round-robin distributor
 * Hands each incoming operand pair to the next lane in turn and waits
 * for that lane even when other lanes are free
 */

`default_nettype none

`include "farm_macros.svh"

module rr_distributor (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    // Input operand stream
    input  logic                       valid_i,
    output logic                       ready_o,
    input  farm_pkg::operand_t         a_i,
    input  farm_pkg::operand_t         b_i,
    // Per-lane handshake with the operands broadcast to every lane
    output logic [`FARM_NUM_LANES-1:0] valid_o,
    input  logic [`FARM_NUM_LANES-1:0] ready_i,
    output farm_pkg::operand_t         a_o,
    output farm_pkg::operand_t         b_o
);

    // Lane that receives the next operand pair
    farm_pkg::lane_idx_t ptr_q;
    farm_pkg::lane_idx_t ptr_d;
    logic                in_fire;

    // A transfer only completes with the lane at the pointer
    assign in_fire = valid_i && ready_i[ptr_q];

    // Step to the next lane after each accepted pair, wrapping at the last lane
    always_comb begin : proc_ptr_next
        ptr_d = ptr_q;
        if (in_fire) begin
            if (ptr_q == farm_pkg::lane_idx_t'(`FARM_NUM_LANES - 1)) begin
                ptr_d = '0;
            end else begin
                ptr_d = ptr_q + 1'b1;
            end
        end
    end

    // Only the selected lane sees valid
    always_comb begin : proc_route_valid
        valid_o        = '0;
        valid_o[ptr_q] = valid_i;
    end

    // The input stalls until the selected lane is idle
    assign ready_o = ready_i[ptr_q];

    // Every lane sees the same operands; valid decides who takes them
    assign a_o = a_i;
    assign b_o = b_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin : proc_ptr
        if (!rst_ni) begin
            ptr_q <= '0;
        end else begin
            ptr_q <= ptr_d;
        end
    end

endmodule : rr_distributor

`default_nettype wire

// File: rtl/mul_lane.sv
/*
 * Iterative multiplier lane
 * Unsigned shift-and-add multiplier taking one step per multiplier bit,
 * with valid/ready handshakes on its input and its output
 */

`default_nettype none

`include "farm_macros.svh"

module mul_lane (
    input  logic               clk_i,
    input  logic               rst_ni,
    // Operand input
    input  logic               valid_i,
    output logic               ready_o,
    input  farm_pkg::operand_t a_i,
    input  farm_pkg::operand_t b_i,
    // Product output
    output logic               valid_o,
    input  logic               ready_i,
    output farm_pkg::product_t prod_o
);

    // Counter has to reach the full step count, one more than the last step index
    localparam int unsigned cnt_w = $clog2(`FARM_MUL_STEPS + 1);

    typedef enum logic [1:0] {
        st_idle,
        st_busy,
        st_done
    } state_e;

    state_e             state_q;
    logic [cnt_w-1:0]   step_q;
    farm_pkg::product_t mcand_q;
    farm_pkg::operand_t mplier_q;
    farm_pkg::product_t acc_q;
    logic               in_fire;
    logic               out_fire;
    logic               last_step;

    assign ready_o  = (state_q == st_idle);
    assign valid_o  = (state_q == st_done);
    assign prod_o   = acc_q;
    assign in_fire  = valid_i && ready_o;
    assign out_fire = valid_o && ready_i;

    // All shift-add steps are done once the counter holds the step count
    assign last_step = (step_q == cnt_w'(`FARM_MUL_STEPS));

    always_ff @(posedge clk_i or negedge rst_ni) begin : proc_ctrl
        if (!rst_ni) begin
            state_q <= st_idle;
            step_q  <= '0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (in_fire) begin
                        state_q <= st_busy;
                        step_q  <= '0;
                    end
                end
                st_busy: begin
                    // One extra busy cycle after the last step moves to done
                    if (last_step) begin
                        state_q <= st_done;
                    end else begin
                        step_q <= step_q + 1'b1;
                    end
                end
                st_done: begin
                    // Product stays on prod_o until the collector takes it
                    if (out_fire) begin
                        state_q <= st_idle;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // The multiplicand moves left while the multiplier moves right,
    // so bit 0 of the multiplier always picks the current partial product
    always_ff @(posedge clk_i) begin : proc_datapath
        if (in_fire) begin
            mcand_q  <= farm_pkg::product_t'(a_i);
            mplier_q <= b_i;
            acc_q    <= '0;
        end else if ((state_q == st_busy) && !last_step) begin
            if (mplier_q[0]) begin
                acc_q <= acc_q + mcand_q;
            end
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

endmodule : mul_lane

`default_nettype wire

// File: rtl/rr_collector.sv
/*
 * Strict round-robin collector
 * Takes lane results in the same lane order the distributor used,
 * which keeps products in the order their operands arrived
 */

`default_nettype none

`include "farm_macros.svh"

module rr_collector (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    // Per-lane result handshake
    input  logic [`FARM_NUM_LANES-1:0] valid_i,
    output logic [`FARM_NUM_LANES-1:0] ready_o,
    input  farm_pkg::product_t         prod_i [`FARM_NUM_LANES],
    // Ordered result stream
    output logic                       valid_o,
    input  logic                       ready_i,
    output farm_pkg::product_t         prod_o
);

    // Lane that owns the next result in input order
    farm_pkg::lane_idx_t ptr_q;
    logic                out_fire;

    // Results from other lanes wait, even when they finished first
    assign valid_o  = valid_i[ptr_q];
    assign prod_o   = prod_i[ptr_q];
    assign out_fire = valid_o && ready_i;

    // Downstream ready reaches only the lane at the pointer
    always_comb begin : proc_route_ready
        ready_o        = '0;
        ready_o[ptr_q] = ready_i;
    end

    // Advance after each delivered product, wrapping at the last lane
    always_ff @(posedge clk_i or negedge rst_ni) begin : proc_ptr
        if (!rst_ni) begin
            ptr_q <= '0;
        end else if (out_fire) begin
            if (ptr_q == farm_pkg::lane_idx_t'(`FARM_NUM_LANES - 1)) begin
                ptr_q <= '0;
            end else begin
                ptr_q <= ptr_q + 1'b1;
            end
        end
    end

endmodule : rr_collector

`default_nettype wire

// File: rtl/mul_farm_top.sv
/*
 * Order-preserving multiplier farm
 * Round-robin distributor feeding a row of iterative multiplier lanes,
 * drained in the same order by a round-robin collector
 */

`default_nettype none

`include "farm_macros.svh"

module mul_farm_top (
    input  logic               clk_i,
    input  logic               rst_ni,
    // Operand pairs in
    input  logic               in_valid_i,
    output logic               in_ready_o,
    input  farm_pkg::operand_t in_a_i,
    input  farm_pkg::operand_t in_b_i,
    // Products out, in input order
    output logic               res_valid_o,
    input  logic               res_ready_i,
    output farm_pkg::product_t res_prod_o
);

    // Distributor to lanes
    logic [`FARM_NUM_LANES-1:0] lane_in_valid;
    logic [`FARM_NUM_LANES-1:0] lane_in_ready;
    farm_pkg::operand_t         lane_a;
    farm_pkg::operand_t         lane_b;

    // Lanes to collector
    logic [`FARM_NUM_LANES-1:0] lane_out_valid;
    logic [`FARM_NUM_LANES-1:0] lane_out_ready;
    farm_pkg::product_t         lane_prod [`FARM_NUM_LANES];

    rr_distributor i_distributor (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .valid_i (in_valid_i),
        .ready_o (in_ready_o),
        .a_i     (in_a_i),
        .b_i     (in_b_i),
        .valid_o (lane_in_valid),
        .ready_i (lane_in_ready),
        .a_o     (lane_a),
        .b_o     (lane_b)
    );

    // One multiplier per lane, all sharing the broadcast operands
    for (genvar i = 0; i < `FARM_NUM_LANES; i++) begin : gen_lane
        mul_lane i_lane (
            .clk_i   (clk_i),
            .rst_ni  (rst_ni),
            .valid_i (lane_in_valid[i]),
            .ready_o (lane_in_ready[i]),
            .a_i     (lane_a),
            .b_i     (lane_b),
            .valid_o (lane_out_valid[i]),
            .ready_i (lane_out_ready[i]),
            .prod_o  (lane_prod[i])
        );
    end

    rr_collector i_collector (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .valid_i (lane_out_valid),
        .ready_o (lane_out_ready),
        .prod_i  (lane_prod),
        .valid_o (res_valid_o),
        .ready_i (res_ready_i),
        .prod_o  (res_prod_o)
    );

endmodule : mul_farm_top

`default_nettype wire

// File: tb/tb_mul_farm.sv
/*
 * Multiplier farm testbench
 * Drives operand pairs into the farm, keeps a queue of expected products
 * and checks reset, ordering, parallelism and back-pressure with assertions
 */

`default_nettype none

`include "farm_macros.svh"

module tb_mul_farm;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned clk_period = 40;
    localparam int unsigned n_lanes    = `FARM_NUM_LANES;
    localparam int unsigned n_steps    = `FARM_MUL_STEPS;
    localparam int unsigned n_burst    = 2 * n_lanes;
    localparam int unsigned n_long     = 200;
    localparam int unsigned n_items    = n_burst + n_lanes + n_long;
    // Worst case every item waits a full round of lanes, plus reset and drain slack
    localparam int unsigned limit_cycles = n_items * (n_steps + 1) * n_lanes + 500;
    localparam logic [31:0] seed = 32'hcea679f3;

    logic               clk_i;
    logic               rst_ni;
    logic               in_valid_i;
    logic               in_ready_o;
    farm_pkg::operand_t in_a_i;
    farm_pkg::operand_t in_b_i;
    logic               res_valid_o;
    logic               res_ready_i;
    farm_pkg::product_t res_prod_o;

    // Expected products in input order with the front mirrored into plain variables
    farm_pkg::product_t exp_q [$];
    farm_pkg::product_t exp_front;
    int unsigned        exp_count;
    int unsigned        edge_idx;
    logic               bp_phase;
    int unsigned        bp_xfers;
    // 0 holds res_ready_i high, 1 holds it low, anything else toggles it randomly
    int unsigned        ready_mode;

    mul_farm_top dut (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_a_i      (in_a_i),
        .in_b_i      (in_b_i),
        .res_valid_o (res_valid_o),
        .res_ready_i (res_ready_i),
        .res_prod_o  (res_prod_o)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        fail_run($sformatf("error: %0d ns %s got %0h expected %0h", $time, name, got, exp));
    endtask

    // Called 2 ns after an edge; returns 2 ns after the edge that took the pair
    task automatic send_pair(input farm_pkg::operand_t a, input farm_pkg::operand_t b);
        logic taken;
        in_valid_i = 1'b1;
        in_a_i     = a;
        in_b_i     = b;
        taken      = 1'b0;
        while (!taken) begin
            @(negedge clk_i);
            taken = in_ready_o;
            @(posedge clk_i);
            #2;
        end
        if (bp_phase) begin
            bp_xfers++;
        end
    endtask

    task automatic send_random_pair();
        send_pair(farm_pkg::operand_t'($urandom), farm_pkg::operand_t'($urandom));
    endtask

    task automatic idle_cycles(input int unsigned n);
        in_valid_i = 1'b0;
        repeat (n) begin
            @(posedge clk_i);
            #2;
        end
    endtask

    task automatic wait_drained();
        in_valid_i = 1'b0;
        while (exp_count != 0) begin
            @(posedge clk_i);
            #2;
        end
    endtask

    initial begin : gen_clock
        clk_i = 1'b0;
        forever begin
            #(clk_period / 2);
            clk_i = ~clk_i;
        end
    end

    // Edge 0 is the first rising edge after reset release
    always @(posedge clk_i) begin : count_edges
        if (!rst_ni) begin
            edge_idx <= 0;
        end else if (edge_idx < 32'hffff) begin
            edge_idx <= edge_idx + 1;
        end
    end

    // The mode is taken at the falling edge and applied after the next rising edge
    initial begin : drive_res_ready
        int unsigned mode;
        res_ready_i = 1'b1;
        forever begin
            @(negedge clk_i);
            mode = ready_mode;
            @(posedge clk_i);
            #2;
            case (mode)
                0: res_ready_i = 1'b1;
                1: res_ready_i = 1'b0;
                default: res_ready_i = ($urandom_range(3) != 0);
            endcase
        end
    end

    // Handshakes are sampled at the falling edge and the queue moves just after the rising one
    initial begin : track_transfers
        logic in_fire;
        logic out_fire;
        forever begin
            @(negedge clk_i);
            in_fire  = rst_ni && in_valid_i && in_ready_o;
            out_fire = rst_ni && res_valid_o && res_ready_i;
            @(posedge clk_i);
            #1;
            if (out_fire && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
            end
            if (in_fire) begin
                exp_q.push_back(farm_pkg::product_t'(in_a_i) * farm_pkg::product_t'(in_b_i));
            end
            exp_count = exp_q.size();
            exp_front = (exp_q.size() > 0) ? exp_q[0] : '0;
        end
    end

    initial begin : watchdog
        #(limit_cycles * clk_period);
        fail_run($sformatf("the run timed out after %0d clock cycles", limit_cycles));
    end

    chk_reset_valid: assert property (@(posedge clk_i)
        (!rst_ni || edge_idx == 0) |-> !res_valid_o)
        else report_mismatch("res_valid_o", 64'($sampled(res_valid_o)), 64'd0);

    chk_reset_ready: assert property (@(posedge clk_i)
        (!rst_ni || edge_idx == 0) |-> in_ready_o)
        else report_mismatch("in_ready_o", 64'($sampled(in_ready_o)), 64'd1);

    chk_no_extra: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (res_valid_o && res_ready_i) |-> exp_count != 0)
        else fail_run("a product left the farm while no operand pair was pending");

    // Comparing against the queue front also proves strict input order
    chk_product: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (res_valid_o && res_ready_i && exp_count != 0) |-> res_prod_o == exp_front)
        else report_mismatch("res_prod_o", 64'($sampled(res_prod_o)),
                             64'($sampled(exp_front)));

    // All lanes are idle after reset, so the first pairs go out back to back
    chk_burst: assert property (@(posedge clk_i) disable iff (!rst_ni)
        edge_idx < n_lanes |-> (in_valid_i && in_ready_o))
        else fail_run("an idle lane did not take its pair in the burst after reset");

    chk_burst_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
        edge_idx < n_lanes |-> !res_valid_o)
        else report_mismatch("res_valid_o", 64'($sampled(res_valid_o)), 64'd0);

    chk_hold_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (res_valid_o && !res_ready_i) |=> res_valid_o)
        else report_mismatch("res_valid_o", 64'($sampled(res_valid_o)), 64'd1);

    chk_hold_prod: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (res_valid_o && !res_ready_i) |=> $stable(res_prod_o))
        else report_mismatch("res_prod_o", 64'($sampled(res_prod_o)),
                             64'($past(res_prod_o)));

    // Every lane holds a result, so the distributor has nowhere to go
    chk_full_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (bp_phase && bp_xfers == n_lanes) |-> !in_ready_o)
        else report_mismatch("in_ready_o", 64'($sampled(in_ready_o)), 64'd0);

    initial begin : run_tests
        void'($urandom(seed));
        rst_ni     = 1'b1;
        in_valid_i = 1'b0;
        in_a_i     = '0;
        in_b_i     = '0;
        exp_count  = 0;
        exp_front  = '0;
        bp_phase   = 1'b0;
        bp_xfers   = 0;
        ready_mode = 0;
        // A real falling edge so the asynchronous reset acts at once
        #1;
        rst_ni = 1'b0;
        repeat (10) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;

        // Burst right after reset with the extreme operand pairs first
        send_pair('0, farm_pkg::operand_t'($urandom));
        send_pair(farm_pkg::operand_t'($urandom), '0);
        send_pair('1, '1);
        send_pair('1, farm_pkg::operand_t'(1));
        for (int unsigned i = 4; i < n_burst; i++) begin
            send_random_pair();
        end
        wait_drained();

        // Fill every lane while the output is blocked
        ready_mode = 1;
        idle_cycles(2);
        bp_phase = 1'b1;
        for (int unsigned i = 0; i < n_lanes; i++) begin
            send_random_pair();
        end
        idle_cycles(2 * (n_steps + 1));
        bp_phase   = 1'b0;
        ready_mode = 0;
        wait_drained();

        // Long run with random input gaps and random output stalls
        ready_mode = 2;
        for (int unsigned i = 0; i < n_long; i++) begin
            if ($urandom_range(3) == 0) begin
                idle_cycles(1);
            end
            send_random_pair();
        end
        wait_drained();
        ready_mode = 0;
        idle_cycles(2);

        $display("all tests passed");
        $finish;
    end

endmodule : tb_mul_farm

`default_nettype wire

// File: sim.f
+incdir+rtl
rtl/farm_pkg.sv
rtl/rr_distributor.sv
rtl/mul_lane.sv
rtl/rr_collector.sv
rtl/mul_farm_top.sv
tb/tb_mul_farm.sv

// File: Makefile
# Verilator build and run for the order-preserving multiplier farm
# The simulation exits with a failing status when the testbench stops on $fatal

OBJ_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module tb_mul_farm -Mdir $(OBJ_DIR) -o sim_mul_farm -f sim.f
	./$(OBJ_DIR)/sim_mul_farm

clean:
	rm -rf $(OBJ_DIR)
